// File: rtl/request_defs.svh
// Sizing for the request concentrator, shared by RTL and testbench
// NUM_REQUESTORS is assumed a power of two so the source tag covers it
// Thresholds keep headroom for the registered ready path and the
// items still in flight between arbiter pop and egress write
`ifndef REQUEST_DEFS_SVH
`define REQUEST_DEFS_SVH

// Engine count and source tag width
`define NUM_REQUESTORS 4
`define SOURCE_WIDTH   $clog2(`NUM_REQUESTORS)

// Request address width
`define ADDR_WIDTH 32

// Per-engine ingress queues
`define INGRESS_DEPTH  16
`define INGRESS_THRESH 10

// Shared egress queue
`define EGRESS_DEPTH  32
`define EGRESS_THRESH 20

// Setup hold after reset release, in cycles
`define SETUP_CYCLES 3

`endif

// File: rtl/request_pkg.sv
// Request, tagged request and queue status types
// Widths come from the sizing macros in request_defs.svh
`include "request_defs.svh"

package request_pkg;

  // ------------------------------------------------------------
  // Engine side
  // ------------------------------------------------------------
  typedef struct packed {
    logic [`ADDR_WIDTH-1:0] address;
    logic [1:0]             command;  // 0 read, 1 write
    logic [7:0]             cookie;   // Engine private tag
  } request_payload_t;

  typedef struct packed {
    logic             valid;
    request_payload_t payload;
  } request_t;

  // ------------------------------------------------------------
  // Memory side, one entry of the egress queue
  // ------------------------------------------------------------
  typedef struct packed {
    logic [`SOURCE_WIDTH-1:0] source;
    request_payload_t         payload;
  } tagged_payload_t;

  typedef struct packed {
    logic            valid;
    tagged_payload_t payload;
  } tagged_request_t;

  // Flags carried out of every queue
  typedef struct packed {
    logic empty;
    logic valid;
    logic prog_full;
  } queue_status_t;

endpackage

// File: rtl/request_queue.sv
// Synchronous FIFO with a registered read port
// Push while full is dropped, pop while empty is ignored
// Read data and status.valid appear the cycle after an accepted pop
// prog_full is high at or above PROG_THRESH entries
`timescale 1ns/1ps

module request_queue #(
  parameter type payload_t   = logic [7:0],
  parameter int  DEPTH       = 16,
  parameter int  PROG_THRESH = 10
) (
  input  logic                       ap_clk,
  input  logic                       areset_control,
  input  logic                       push,
  input  payload_t                   push_data,
  input  logic                       pop,
  output payload_t                   pop_data,
  output request_pkg::queue_status_t status
);

  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  // Storage and pointers
  payload_t               mem [DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   rd_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic                   full;
  logic                   do_push;
  logic                   do_pop;
  logic                   data_valid;

  // Wrap at DEPTH, so depth need not be a power of two
  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full    = (count == COUNT_WIDTH'(DEPTH));
  assign do_push = push & ~full;
  assign do_pop  = pop & (count != '0);

  // ------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      data_valid <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One pulse per entry read
      data_valid <= do_pop;
    end
  end

  // ------------------------------------------------------------
  // Storage and read port
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
    if (do_pop) begin
      pop_data <= mem[rd_ptr];
    end
  end

  // Status flags
  assign status.empty     = (count == '0);
  assign status.valid     = data_valid;
  assign status.prog_full = (count >= COUNT_WIDTH'(PROG_THRESH));

endmodule

// File: rtl/request_ingress.sv
// Input register stage for all engines
// Drives a registered copy of the reset to the queues and arbiter
// Ready is low in reset and while setup is high
// Engines must drive valid only while their ready bit is high
`timescale 1ns/1ps
`include "request_defs.svh"

module request_ingress (
  input  logic                              ap_clk,
  input  logic                              areset_control,
  input  request_pkg::request_t             request_in [`NUM_REQUESTORS-1:0],
  input  request_pkg::queue_status_t        ingress_status [`NUM_REQUESTORS-1:0],
  input  request_pkg::queue_status_t        egress_status,
  output request_pkg::request_t             push_request [`NUM_REQUESTORS-1:0],
  output logic                              queue_reset,
  output logic [`NUM_REQUESTORS-1:0]        request_ready,
  output logic                              setup
);

  localparam int SETUP_WIDTH = $clog2(`SETUP_CYCLES + 1);

  logic [SETUP_WIDTH-1:0] setup_count;

  // Local reset copy for the queue side
  always_ff @(posedge ap_clk) begin
    queue_reset <= areset_control;
  end

  // ------------------------------------------------------------
  // Request register, valid cleared in reset
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < `NUM_REQUESTORS; i++) begin
      if (areset_control) begin
        push_request[i].valid <= 1'b0;
      end else begin
        push_request[i].valid <= request_in[i].valid;
      end
      push_request[i].payload <= request_in[i].payload;
    end
  end

  // ------------------------------------------------------------
  // Setup hold, falls SETUP_CYCLES after reset release
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      setup_count <= SETUP_WIDTH'(`SETUP_CYCLES);
      setup       <= 1'b1;
    end else begin
      if (setup_count != '0) begin
        setup_count <= setup_count - 1'b1;
      end
      // Last count step clears setup
      setup <= (setup_count > SETUP_WIDTH'(1));
    end
  end

  // Ready per engine from its own queue and the egress queue
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      request_ready <= '0;
    end else begin
      for (int i = 0; i < `NUM_REQUESTORS; i++) begin
        request_ready[i] <= ~setup & ~ingress_status[i].prog_full &
                            ~egress_status.prog_full;
      end
    end
  end

endmodule

// File: rtl/request_rr_arbiter.sv
// Round-robin drain of the ingress queues into the egress queue
// One queue popped per cycle, priority starts just after the last grant
// Pops pause while the egress queue is at its programmable-full level
// Output is registered and tagged with the source queue index
`timescale 1ns/1ps
`include "request_defs.svh"

module request_rr_arbiter (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  request_pkg::queue_status_t    queue_status [`NUM_REQUESTORS-1:0],
  input  request_pkg::request_payload_t queue_data [`NUM_REQUESTORS-1:0],
  input  request_pkg::queue_status_t    egress_status,
  output logic [`NUM_REQUESTORS-1:0]    arbiter_pop,
  output request_pkg::tagged_request_t  egress_push
);

  localparam int N  = `NUM_REQUESTORS;
  localparam int SW = `SOURCE_WIDTH;

  logic [N-1:0]  request;
  logic [N-1:0]  grant;
  logic [SW-1:0] grant_index;
  logic          grant_any;
  logic [SW-1:0] last_grant;
  logic [SW-1:0] data_index;
  logic          data_valid;

  // ------------------------------------------------------------
  // Grant, search starts one past the last winner
  // ------------------------------------------------------------
  always_comb begin
    int idx;
    grant       = '0;
    grant_index = last_grant;
    grant_any   = 1'b0;
    for (int i = 0; i < N; i++) begin
      request[i] = ~queue_status[i].empty;
    end
    for (int off = 1; off <= N; off++) begin
      idx = (int'(last_grant) + off) % N;
      // Egress near full holds every queue
      if (!grant_any && request[idx] && !egress_status.prog_full) begin
        grant[idx]  = 1'b1;
        grant_index = SW'(idx);
        grant_any   = 1'b1;
      end
    end
  end

  assign arbiter_pop = grant;

  // Priority pointer, port 0 first after reset
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      last_grant <= SW'(N - 1);
    end else if (grant_any) begin
      last_grant <= grant_index;
    end
  end

  // ------------------------------------------------------------
  // Capture returning data with its source tag
  // ------------------------------------------------------------
  always_comb begin
    data_index = '0;
    data_valid = 1'b0;
    // At most one queue returns data per cycle
    for (int i = 0; i < N; i++) begin
      if (queue_status[i].valid) begin
        data_index = SW'(i);
        data_valid = 1'b1;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      egress_push.valid <= 1'b0;
    end else begin
      egress_push.valid <= data_valid;
    end
    egress_push.payload.source  <= data_index;
    egress_push.payload.payload <= queue_data[data_index];
  end

endmodule

// File: rtl/request_concentrator.sv
// Memory request concentrator top
// Each engine has its own ingress queue, drained round-robin into one
// tagged egress queue that the memory side pops with egress_pop
// request_out.valid is a one-cycle pulse per request, no stall on output
`timescale 1ns/1ps
`include "request_defs.svh"

module request_concentrator (
  input  logic                         ap_clk,
  input  logic                         areset_control,
  input  request_pkg::request_t        request_in [`NUM_REQUESTORS-1:0],
  input  logic                         egress_pop,
  output logic [`NUM_REQUESTORS-1:0]   request_ready,
  output request_pkg::tagged_request_t request_out,
  output logic                         setup
);

  // ------------------------------------------------------------
  // Internal wiring
  // ------------------------------------------------------------
  request_pkg::request_t         push_request [`NUM_REQUESTORS-1:0];
  logic                          queue_reset;
  request_pkg::queue_status_t    ingress_status [`NUM_REQUESTORS-1:0];
  request_pkg::request_payload_t ingress_data [`NUM_REQUESTORS-1:0];
  logic [`NUM_REQUESTORS-1:0]    arbiter_pop;
  request_pkg::tagged_request_t  egress_push;
  request_pkg::queue_status_t    egress_status;
  request_pkg::tagged_payload_t  egress_data;

  // Input registers, reset copy, ready and setup
  request_ingress u_ingress (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .request_in     (request_in),
    .ingress_status (ingress_status),
    .egress_status  (egress_status),
    .push_request   (push_request),
    .queue_reset    (queue_reset),
    .request_ready  (request_ready),
    .setup          (setup)
  );

  // One queue per engine
  for (genvar i = 0; i < `NUM_REQUESTORS; i++) begin : g_ingress_queue
    request_queue #(
      .payload_t   (request_pkg::request_payload_t),
      .DEPTH       (`INGRESS_DEPTH),
      .PROG_THRESH (`INGRESS_THRESH)
    ) u_queue (
      .ap_clk         (ap_clk),
      .areset_control (queue_reset),
      .push           (push_request[i].valid),
      .push_data      (push_request[i].payload),
      .pop            (arbiter_pop[i]),
      .pop_data       (ingress_data[i]),
      .status         (ingress_status[i])
    );
  end

  // Merge and tag
  request_rr_arbiter u_arbiter (
    .ap_clk         (ap_clk),
    .areset_control (queue_reset),
    .queue_status   (ingress_status),
    .queue_data     (ingress_data),
    .egress_status  (egress_status),
    .arbiter_pop    (arbiter_pop),
    .egress_push    (egress_push)
  );

  // Shared tagged queue toward memory
  request_queue #(
    .payload_t   (request_pkg::tagged_payload_t),
    .DEPTH       (`EGRESS_DEPTH),
    .PROG_THRESH (`EGRESS_THRESH)
  ) u_egress_queue (
    .ap_clk         (ap_clk),
    .areset_control (queue_reset),
    .push           (egress_push.valid),
    .push_data      (egress_push.payload),
    .pop            (egress_pop),
    .pop_data       (egress_data),
    .status         (egress_status)
  );

  // ------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      request_out.valid <= 1'b0;
    end else begin
      request_out.valid <= egress_status.valid;
    end
    request_out.payload <= egress_data;
  end

endmodule

// File: bench/request_concentrator_assert.sv
// Concurrent checks bound into the queues and the arbiter
// Disabled while the local reset is high or still unknown
// A queue binding ties the read and grant inputs low, the arbiter ties push low
`timescale 1ns/1ps

module request_concentrator_assert #(
  parameter int WIDTH = 1
) (
  input logic             ap_clk,
  input logic             areset_control,
  input logic             push,
  input logic             full,
  input logic             read_pop,
  input logic             read_valid,
  input logic [WIDTH-1:0] grant
);

  // Push into a full queue loses a request
  no_overflow: assert property (@(posedge ap_clk) disable iff (areset_control !== 1'b0)
    !(push && full))
    else $error("queue written while full");

  // Data returns only the cycle after an accepted pop
  no_underflow: assert property (@(posedge ap_clk) disable iff (areset_control !== 1'b0)
    read_valid |-> $past(read_pop))
    else $error("read data without a pop of a non-empty queue");

  grant_one_hot: assert property (@(posedge ap_clk) disable iff (areset_control !== 1'b0)
    $onehot0(grant))
    else $error("more than one queue granted");

endmodule

// File: bench/request_concentrator_checker.sv
// Scoreboard on the concentrator ports
// Requests are recorded per source as they enter, outputs must match in order
// Also checks reset state, setup timing and fairness while fair_check is high
`timescale 1ns/1ps
`include "request_defs.svh"

module request_concentrator_checker (
  input  logic                         ap_clk,
  input  logic                         areset_control,
  input  request_pkg::request_t        request_in [`NUM_REQUESTORS-1:0],
  input  logic                         egress_pop,
  input  logic [`NUM_REQUESTORS-1:0]   request_ready,
  input  logic                         setup,
  input  request_pkg::tagged_request_t request_out,
  input  logic                         fair_check,
  output int                           error_count,
  output int                           in_count,
  output int                           out_count
);

  localparam int N = `NUM_REQUESTORS;

  // Pending requests, one queue per source
  request_pkg::request_payload_t expected [N][$];
  logic [`SOURCE_WIDTH-1:0]      recent [$];
  int   errors      = 0;
  int   inputs      = 0;
  int   outputs     = 0;
  int   post_cycles = 0;
  logic reset_seen  = 1'b0;
  logic pop_d1      = 1'b0;
  logic pop_d2      = 1'b0;

  assign error_count = errors;
  assign in_count    = inputs;
  assign out_count   = outputs;

  always @(posedge ap_clk) begin
    request_pkg::request_payload_t want;
    logic [`SOURCE_WIDTH-1:0]      src;
    logic                          setup_expect;
    if (areset_control === 1'b1) begin
      // Held reset, outputs quiet and setup high
      if (reset_seen && (request_ready !== '0 || request_out.valid !== 1'b0 ||
                         setup !== 1'b1)) begin
        $display("CHECK FAILED at %0t: reset state wrong, ready %b valid %b setup %b",
                 $time, request_ready, request_out.valid, setup);
        errors++;
      end
      reset_seen  = 1'b1;
      post_cycles = 0;
    end else if (reset_seen) begin
      // ------------------------------------------------------------
      // Setup falls SETUP_CYCLES edges after release
      // ------------------------------------------------------------
      setup_expect = (post_cycles < `SETUP_CYCLES);
      if (setup !== setup_expect) begin
        $display("CHECK FAILED at %0t: setup %b, expected %b after %0d cycles",
                 $time, setup, setup_expect, post_cycles);
        errors++;
      end
      if (setup === 1'b1 && request_ready !== '0) begin
        $display("CHECK FAILED at %0t: ready %b while setup high", $time, request_ready);
        errors++;
      end
      if (post_cycles < `SETUP_CYCLES) begin
        post_cycles++;
      end

      // Record accepted requests
      for (int i = 0; i < N; i++) begin
        if (request_in[i].valid === 1'b1) begin
          if (request_ready[i] !== 1'b1) begin
            $display("Engine %0d drove a request at %0t while its ready was low", i, $time);
            errors++;
          end
          expected[i].push_back(request_in[i].payload);
          inputs++;
        end
      end

      // ------------------------------------------------------------
      // Compare each output with the oldest request of its source
      // ------------------------------------------------------------
      if (request_out.valid === 1'b1) begin
        src = request_out.payload.source;
        outputs++;
        if (!pop_d2) begin
          $display("Output at %0t without an egress pop two cycles before", $time);
          errors++;
        end
        if (expected[src].size() == 0) begin
          $display("Output from source %0d at %0t with no request pending", src, $time);
          errors++;
        end else begin
          want = expected[src].pop_front();
          if (request_out.payload.payload !== want) begin
            $display("CHECK FAILED at %0t: source %0d expected %h, got %h",
                     $time, src, want, request_out.payload.payload);
            errors++;
          end
        end
        // Engine field of the address names the source
        if (request_out.payload.payload.address[`ADDR_WIDTH-1 -: 8] != 8'(src)) begin
          $display("CHECK FAILED at %0t: tag %0d does not match address %h",
                   $time, src, request_out.payload.payload.address);
          errors++;
        end
        // No source twice within any N outputs
        if (fair_check) begin
          foreach (recent[k]) begin
            if (recent[k] == src) begin
              $display("Source %0d repeated within %0d outputs at %0t", src, N, $time);
              errors++;
            end
          end
          recent.push_back(src);
          if (recent.size() > N - 1) begin
            void'(recent.pop_front());
          end
        end
      end
    end
    if (!fair_check) begin
      recent.delete();
    end
    pop_d2 = pop_d1;
    pop_d1 = egress_pop;
  end

endmodule

// File: bench/request_concentrator_tb.sv
// Testbench for the request concentrator
// Rows of the stimulus table run one after another, each drains fully
// Inputs change 1 ns after the rising edge, the checker samples on the edge
// Run length is bounded by a cycle counter sized from the table
`timescale 1ns/1ps
`include "request_defs.svh"

module request_concentrator_tb;

  localparam int N = `NUM_REQUESTORS;
  localparam logic [1:0] POP_ALWAYS = 2'd0;
  localparam logic [1:0] POP_RANDOM = 2'd1;
  localparam logic [1:0] POP_HOLD   = 2'd2;
  localparam int NUM_ROWS    = 6;
  localparam int HOLD_STREAK = 16;

  // One row of stimulus
  typedef struct packed {
    logic [N-1:0] mask;
    logic [7:0]   count;
    logic [7:0]   cookie_base;
    logic [1:0]   pop_mode;
    logic         fair;
  } row_t;

  row_t rows [NUM_ROWS] = '{
    '{4'b0001, 8'd20, 8'h10, POP_ALWAYS, 1'b0},
    '{4'b0100, 8'd12, 8'h40, POP_RANDOM, 1'b0},
    '{4'b1111, 8'd16, 8'h80, POP_ALWAYS, 1'b0},
    '{4'b1111, 8'd12, 8'hc0, POP_HOLD,   1'b1},
    '{4'b1011, 8'd10, 8'h20, POP_RANDOM, 1'b0},
    '{4'b1111, 8'd8,  8'he0, POP_RANDOM, 1'b0}
  };

  logic                         ap_clk;
  logic                         areset_control;
  request_pkg::request_t        request_in [N-1:0];
  logic                         egress_pop;
  logic [N-1:0]                 request_ready;
  request_pkg::tagged_request_t request_out;
  logic                         setup;
  logic                         fair_check;
  logic                         sent_done;
  logic [15:0]                  lfsr_state = 16'd2071;
  int                           error_count;
  int                           in_count;
  int                           out_count;
  int                           cycle_count = 0;
  int                           cycle_limit = 0;

  request_concentrator dut0 (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .request_in     (request_in),
    .egress_pop     (egress_pop),
    .request_ready  (request_ready),
    .request_out    (request_out),
    .setup          (setup)
  );

  request_concentrator_checker u_checker (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .request_in     (request_in),
    .egress_pop     (egress_pop),
    .request_ready  (request_ready),
    .setup          (setup),
    .request_out    (request_out),
    .fair_check     (fair_check),
    .error_count    (error_count),
    .in_count       (in_count),
    .out_count      (out_count)
  );

  // ------------------------------------------------------------
  // Bound checks in every queue and the arbiter
  // ------------------------------------------------------------
  bind request_queue request_concentrator_assert #(.WIDTH(1)) u_queue_assert (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .push           (push),
    .full           (full),
    .read_pop       (1'b0),
    .read_valid     (1'b0),
    .grant          (1'b0)
  );

  bind request_rr_arbiter request_concentrator_assert #(.WIDTH(`NUM_REQUESTORS)) u_arb_assert (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .push           (1'b0),
    .full           (1'b0),
    .read_pop       (|arbiter_pop),
    .read_valid     (data_valid),
    .grant          (grant)
  );

  initial begin
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;
  end

  // Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
  endfunction

  // Engine field in the top address byte, index below
  function automatic request_pkg::request_payload_t make_payload(input int src, input int idx,
                                                                 input logic [7:0] base);
    request_pkg::request_payload_t p;
    p.address = (`ADDR_WIDTH'(src) << 24) | `ADDR_WIDTH'(idx);
    p.command = 2'(idx % 2);
    p.cookie  = base + 8'(idx);
    return p;
  endfunction

  function automatic int table_total();
    int total;
    total = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total += $countones(rows[r].mask) * int'(rows[r].count);
    end
    return total;
  endfunction

  // Send each masked engine's requests while its ready is high
  task automatic drive_row(input row_t row);
    int sent [N];
    int left;
    left = $countones(row.mask) * int'(row.count);
    for (int i = 0; i < N; i++) begin
      sent[i] = 0;
    end
    while (left > 0) begin
      @(posedge ap_clk);
      #1;
      for (int i = 0; i < N; i++) begin
        request_in[i] = '0;
        if (row.mask[i] && sent[i] < int'(row.count) && request_ready[i]) begin
          request_in[i].valid   = 1'b1;
          request_in[i].payload = make_payload(i, sent[i], row.cookie_base);
          sent[i]++;
          left--;
        end
      end
    end
    @(posedge ap_clk);
    #1;
    for (int i = 0; i < N; i++) begin
      request_in[i] = '0;
    end
    sent_done = 1'b1;
  endtask

  // Egress side, optional hold until back-pressure reaches every engine
  task automatic pop_row(input row_t row);
    int   low_streak;
    logic bit_a;
    logic bit_b;
    low_streak = 0;
    if (row.pop_mode == POP_HOLD) begin
      egress_pop = 1'b0;
      while (!(sent_done && low_streak >= HOLD_STREAK)) begin
        @(posedge ap_clk);
        #1;
        low_streak = (request_ready == '0) ? low_streak + 1 : 0;
      end
    end
    while (!(sent_done && out_count == in_count)) begin
      @(posedge ap_clk);
      #1;
      if (row.pop_mode == POP_RANDOM) begin
        // Two bits per decision, pop three times in four
        lfsr_state = lfsr_next(lfsr_state);
        bit_a      = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        bit_b      = lfsr_state[0];
        egress_pop = bit_a | bit_b;
      end else begin
        egress_pop = 1'b1;
      end
    end
    egress_pop = 1'b0;
  endtask

  // Watchdog
  always @(posedge ap_clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, %0d of %0d requests came out",
               cycle_count, out_count, in_count);
      $display("Test failures found");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    int errors_before;
    int out_before;
    int expected_total;
    expected_total = table_total();
    cycle_limit    = expected_total * 8 + 200;
    areset_control = 1'b1;
    egress_pop     = 1'b0;
    fair_check     = 1'b0;
    sent_done      = 1'b0;
    for (int i = 0; i < N; i++) begin
      request_in[i] = '0;
    end
    repeat (5) @(posedge ap_clk);
    #1;
    areset_control = 1'b0;

    // Setup must clear, then every ready bit rises
    while (setup !== 1'b0) begin
      @(posedge ap_clk);
      #1;
    end
    while (request_ready !== '1) begin
      @(posedge ap_clk);
      #1;
    end
    $display("reset: setup released, ready high, errors %0d", error_count);

    for (int r = 0; r < NUM_ROWS; r++) begin
      errors_before = error_count;
      out_before    = out_count;
      fair_check    = rows[r].fair;
      sent_done     = 1'b0;
      fork
        drive_row(rows[r]);
        pop_row(rows[r]);
      join
      fair_check = 1'b0;
      $display("row %0d: mask %b, %0d requests out, errors %0d",
               r, rows[r].mask, out_count - out_before, error_count - errors_before);
    end

    $display("done: %0d requests in, %0d out, %0d expected, %0d errors",
             in_count, out_count, expected_total, error_count);
    if (error_count == 0 && in_count == expected_total && out_count == in_count) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+rtl
rtl/request_pkg.sv
rtl/request_queue.sv
rtl/request_ingress.sv
rtl/request_rr_arbiter.sv
rtl/request_concentrator.sv
bench/request_concentrator_assert.sv
bench/request_concentrator_checker.sv
bench/request_concentrator_tb.sv
